//--- leak_obs.f
+incdir+src
src/leak_obs_pkg.sv
src/leak_obs_decode.sv
src/leak_obs_execute.sv
src/leak_obs_result.sv
src/leak_obs_top.sv
verif/leak_obs_checker.sv
verif/leak_obs_tb.sv

//--- verif/leak_obs_tb.sv
`timescale 1ns/1ps
`include "leak_obs_defines.svh"

module leak_obs_tb;

	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 10;
	localparam int WAIT_LIMIT = 200;

	logic clk_i;
	logic rst_i;
	logic in_valid_i;
	leak_obs_pkg::obs_req_t in_req_i;
	logic in_ready_o;
	logic out_valid_o;
	leak_obs_pkg::obs_t out_obs_o;
	logic out_ready_i;

	integer seed;
	int unsigned cycle;
	logic lat_check;
	logic toggling;
	// expected records and acceptance cycles, both in arrival order
	leak_obs_pkg::obs_t exp_q[$];
	int unsigned acc_q[$];

	leak_obs_top dut (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.in_valid_i  (in_valid_i),
		.in_req_i    (in_req_i),
		.in_ready_o  (in_ready_o),
		.out_valid_o (out_valid_o),
		.out_obs_o   (out_obs_o),
		.out_ready_i (out_ready_i)
	);

	always #(CLK_PERIOD / 2) clk_i = ~clk_i;

	task automatic abort_run(input string line);
		$display("%s", line);
		$display("SOME TESTS FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_word(input leak_obs_pkg::word_t got, input leak_obs_pkg::word_t exp,
		input string what);
		if (got !== exp) begin
			abort_run($sformatf("[FAIL] %0t %s: got %h, expected %h", $time, what, got, exp));
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			abort_run($sformatf("[FAIL] %0t %s: got %b, expected %b", $time, what, got, exp));
		end
	endtask

	task automatic check_class(input leak_obs_pkg::obs_class_e got,
		input leak_obs_pkg::obs_class_e exp, input string what);
		if (got !== exp) begin
			abort_run($sformatf("[FAIL] %0t %s: got %0d, expected %0d", $time, what, got, exp));
		end
	endtask

	task automatic check_reg(input leak_obs_pkg::reg_addr_t got,
		input leak_obs_pkg::reg_addr_t exp, input string what);
		if (got !== exp) begin
			abort_run($sformatf("[FAIL] %0t %s: got x%0d, expected x%0d", $time, what, got, exp));
		end
	endtask

	task automatic check_count(input int unsigned got, input int unsigned exp, input string what);
		if (got != exp) begin
			abort_run($sformatf("[FAIL] %0t %s: got %0d, expected %0d", $time, what, got, exp));
		end
	endtask

	task automatic compare_obs(input leak_obs_pkg::obs_t got, input leak_obs_pkg::obs_t exp);
		check_class(got.cls, exp.cls, "class");
		check_reg(got.rs1, exp.rs1, "rs1 index");
		check_reg(got.rs2, exp.rs2, "rs2 index");
		check_word(got.addr, exp.addr, "address");
		check_flag(got.misaligned, exp.misaligned, "misaligned");
		check_flag(got.taken, exp.taken, "branch taken");
		check_word(got.op_b, exp.op_b, "operand b");
		check_flag(got.div_zero, exp.div_zero, "divisor zero");
	endtask

	// expected observation straight from the ISA rules
	function automatic leak_obs_pkg::obs_t model_obs(input leak_obs_pkg::obs_req_t req);
		leak_obs_pkg::obs_t o;
		logic [6:0] opc;
		logic [2:0] f3;
		leak_obs_pkg::word_t a;
		leak_obs_pkg::word_t b;
		leak_obs_pkg::word_t ea;
		opc = req.instr[6:0];
		f3 = req.instr[14:12];
		a = req.rs1_val;
		b = req.rs2_val;
		o = '0;
		o.rs1 = req.instr[19:15];
		o.rs2 = req.instr[24:20];
		if (opc == `LEAK_OBS_OPC_LOAD) begin
			o.cls = leak_obs_pkg::OBS_LOAD;
			ea = a + {{20{req.instr[31]}}, req.instr[31:20]};
		end else if (opc == `LEAK_OBS_OPC_STORE) begin
			o.cls = leak_obs_pkg::OBS_STORE;
			ea = a + {{20{req.instr[31]}}, req.instr[31:25], req.instr[11:7]};
		end else if (opc == `LEAK_OBS_OPC_BRANCH) begin
			o.cls = leak_obs_pkg::OBS_BRANCH;
			case (f3)
				3'd1: o.taken = (a != b);
				3'd4: o.taken = ($signed(a) < $signed(b));
				3'd5: o.taken = ($signed(a) >= $signed(b));
				3'd6: o.taken = (a < b);
				3'd7: o.taken = (a >= b);
				default: o.taken = (a == b);
			endcase
		end else if (opc == `LEAK_OBS_OPC_OP && req.instr[31:25] == `LEAK_OBS_F7_MULDIV) begin
			o.cls = (f3 < 3'd4) ? leak_obs_pkg::OBS_MUL : leak_obs_pkg::OBS_DIV;
			o.op_b = b;
			o.div_zero = (f3 >= 3'd4) && (b == '0);
		end
		if (o.cls == leak_obs_pkg::OBS_LOAD || o.cls == leak_obs_pkg::OBS_STORE) begin
			o.addr = ea;
			// LBU and LHU share the size of LB and LH
			case (f3[1:0])
				2'd0: o.misaligned = 1'b0;
				2'd1: o.misaligned = (ea[1:0] == 2'd3);
				default: o.misaligned = (ea[1:0] != 2'd0);
			endcase
		end
		return o;
	endfunction

	function automatic leak_obs_pkg::word_t encode_mem(input logic [6:0] opc, input logic [2:0] f3,
		input leak_obs_pkg::reg_addr_t rs1, input leak_obs_pkg::reg_addr_t rs2,
		input logic [11:0] imm);
		if (opc == `LEAK_OBS_OPC_STORE) begin
			return {imm[11:5], rs2, rs1, f3, imm[4:0], opc};
		end
		return {imm, rs1, f3, 5'd7, opc};
	endfunction

	function automatic leak_obs_pkg::word_t encode_r_form(input logic [6:0] f7,
		input logic [2:0] f3, input leak_obs_pkg::reg_addr_t rs1,
		input leak_obs_pkg::reg_addr_t rs2, input logic [6:0] opc);
		return {f7, rs2, rs1, f3, 5'd3, opc};
	endfunction

	function automatic leak_obs_pkg::reg_addr_t rand_reg();
		logic [31:0] r;
		r = $random(seed);
		return r[4:0];
	endfunction

	function automatic leak_obs_pkg::word_t random_instr();
		logic [31:0] r;
		r = $random(seed);
		case (r[2:0])
			3'd0: return encode_mem(`LEAK_OBS_OPC_LOAD, {1'b0, r[4:3]}, rand_reg(), 5'd0, r[31:20]);
			3'd1: return encode_mem(`LEAK_OBS_OPC_STORE, {1'b0, r[4:3]}, rand_reg(), rand_reg(),
				r[31:20]);
			3'd2: return encode_r_form(r[31:25], r[5:3], rand_reg(), rand_reg(),
				`LEAK_OBS_OPC_BRANCH);
			3'd3: return encode_r_form(`LEAK_OBS_F7_MULDIV, r[5:3], rand_reg(), rand_reg(),
				`LEAK_OBS_OPC_OP);
			default: return encode_r_form(7'h00, 3'd0, rand_reg(), rand_reg(), `LEAK_OBS_OPC_OP);
		endcase
	endfunction

	// hold the request until the DUT takes it
	task automatic send_req(input leak_obs_pkg::obs_req_t req);
		int n;
		logic accepted;
		@(negedge clk_i);
		exp_q.push_back(model_obs(req));
		in_valid_i = 1'b1;
		in_req_i = req;
		accepted = 1'b0;
		n = 0;
		while (!accepted) begin
			@(posedge clk_i);
			accepted = in_ready_o;
			n++;
			if (!accepted && n >= WAIT_LIMIT) begin
				abort_run("timeout: the DUT never accepted an input request");
			end
		end
	endtask

	task automatic send_instr(input leak_obs_pkg::word_t instr, input leak_obs_pkg::word_t a,
		input leak_obs_pkg::word_t b);
		leak_obs_pkg::obs_req_t req;
		req.instr = instr;
		req.rs1_val = a;
		req.rs2_val = b;
		send_req(req);
	endtask

	task automatic release_input();
		@(negedge clk_i);
		in_valid_i = 1'b0;
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		while (exp_q.size() != 0) begin
			@(negedge clk_i);
			n++;
			if (exp_q.size() != 0 && n >= WAIT_LIMIT) begin
				abort_run("timeout: expected output records never came out of the DUT");
			end
		end
	endtask

	// every output transfer is matched against the oldest expected record
	always @(posedge clk_i) begin : monitor
		leak_obs_pkg::obs_t exp;
		int unsigned acc;
		cycle = cycle + 1;
		if (!rst_i) begin
			if (in_valid_i && in_ready_o) begin
				acc_q.push_back(cycle);
			end
			if (out_valid_o && out_ready_i) begin
				if (exp_q.size() == 0) begin
					abort_run("the DUT produced an output record with no input to match it");
				end else begin
					exp = exp_q.pop_front();
					acc = acc_q.pop_front();
					compare_obs(out_obs_o, exp);
					if (lat_check) begin
						check_count(cycle - acc, 3, "cycles from input to output");
					end
				end
			end
		end
	end

	task automatic test_mem_access();
		logic [2:0] sizes [5];
		leak_obs_pkg::word_t base;
		logic [11:0] imm;
		sizes = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
		foreach (sizes[i]) begin
			// walk the low address bits so every offset is seen
			for (int off = 0; off < 4; off++) begin
				base = $random(seed);
				imm = $random(seed);
				base[1:0] = off[1:0];
				imm[1:0] = 2'b00;
				send_instr(encode_mem(`LEAK_OBS_OPC_LOAD, sizes[i], rand_reg(), 5'd0, imm), base,
					$random(seed));
				if (i < 3) begin
					imm = $random(seed);
					send_instr(encode_mem(`LEAK_OBS_OPC_STORE, sizes[i], rand_reg(), rand_reg(), imm),
						$random(seed), $random(seed));
				end
			end
		end
		release_input();
		wait_drain();
	endtask

	task automatic test_branch();
		logic [2:0] ops [6];
		leak_obs_pkg::word_t a;
		leak_obs_pkg::word_t instr;
		ops = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
		foreach (ops[i]) begin
			for (int k = 0; k < 5; k++) begin
				a = $random(seed);
				instr = encode_r_form(7'h2a, ops[i], rand_reg(), rand_reg(), `LEAK_OBS_OPC_BRANCH);
				case (k)
					0: send_instr(instr, a, a);
					1: send_instr(instr, a | 32'h8000_0000, a & 32'h7fff_ffff);
					2: send_instr(instr, a & 32'h7fff_ffff, a | 32'h8000_0000);
					default: send_instr(instr, a, $random(seed));
				endcase
			end
		end
		release_input();
		wait_drain();
	endtask

	task automatic test_muldiv();
		leak_obs_pkg::word_t instr;
		for (int f3 = 0; f3 < 8; f3++) begin
			instr = encode_r_form(`LEAK_OBS_F7_MULDIV, f3[2:0], rand_reg(), rand_reg(),
				`LEAK_OBS_OPC_OP);
			send_instr(instr, $random(seed), $random(seed) | 32'h1);
			send_instr(instr, $random(seed), '0);
		end
		release_input();
		wait_drain();
	endtask

	task automatic test_other();
		// ADDI, ADD, SUB, LUI and JAL
		send_instr({12'h7f5, rand_reg(), 3'd0, 5'd1, 7'h13}, $random(seed), $random(seed));
		send_instr(encode_r_form(7'h00, 3'd0, rand_reg(), rand_reg(), `LEAK_OBS_OPC_OP),
			$random(seed), 32'h0);
		send_instr(encode_r_form(7'h20, 3'd0, rand_reg(), rand_reg(), `LEAK_OBS_OPC_OP),
			$random(seed), $random(seed));
		send_instr({20'hbeef1, 5'd4, 7'h37}, $random(seed), $random(seed));
		send_instr({20'h12345, 5'd1, 7'h6f}, $random(seed), $random(seed));
		release_input();
		wait_drain();
	endtask

	task automatic test_stream();
		leak_obs_pkg::obs_req_t reqs [$];
		leak_obs_pkg::obs_req_t req;
		logic [31:0] r;
		for (int i = 0; i < 40; i++) begin
			req.instr = random_instr();
			req.rs1_val = $random(seed);
			req.rs2_val = (i % 7 == 0) ? 32'h0 : $random(seed);
			reqs.push_back(req);
		end
		lat_check = 1'b0;
		toggling = 1'b1;
		fork
			begin
				foreach (reqs[i]) begin
					send_req(reqs[i]);
				end
				release_input();
				wait_drain();
				toggling = 1'b0;
			end
			begin
				while (toggling) begin
					@(negedge clk_i);
					r = $random(seed);
					out_ready_i = r[0];
				end
			end
		join
		// same stream again at full rate
		@(negedge clk_i);
		out_ready_i = 1'b1;
		lat_check = 1'b1;
		foreach (reqs[i]) begin
			send_req(reqs[i]);
		end
		release_input();
		wait_drain();
		// a duplicated record would leave the three slots within this window
		repeat (3) @(negedge clk_i);
	endtask

	initial begin
		seed = 32'hbb54;
		clk_i = 1'b0;
		rst_i = 1'b1;
		in_valid_i = 1'b0;
		in_req_i = '0;
		out_ready_i = 1'b1;
		cycle = 0;
		lat_check = 1'b1;
		toggling = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_i);
		@(negedge clk_i);
		rst_i = 1'b0;
		check_flag(out_valid_o, 1'b0, "out_valid_o after reset");
		check_flag(in_ready_o, 1'b1, "in_ready_o after reset");
		test_mem_access();
		test_branch();
		test_muldiv();
		test_other();
		test_stream();
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

//--- verif/leak_obs_checker.sv
`timescale 1ns/1ps

module leak_obs_checker (
	input logic                   clk_i,
	input logic                   rst_i,
	input logic                   in_valid_i,
	input leak_obs_pkg::obs_req_t in_req_i,
	input logic                   in_ready_o,
	input logic                   out_valid_o,
	input leak_obs_pkg::obs_t     out_obs_o,
	input logic                   out_ready_i
);

	// every slot is emptied by reset
	reset_clears_out: assert property (@(posedge clk_i) rst_i |=> !out_valid_o)
		else $error("out_valid_o high right after a reset cycle");

	// a stalled record must not change
	out_held_on_stall: assert property (@(posedge clk_i) disable iff (rst_i)
		out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_obs_o))
		else $error("output record changed or dropped while stalled");

	in_held_on_stall: assert property (@(posedge clk_i) disable iff (rst_i)
		in_valid_i && !in_ready_o |=> in_valid_i && $stable(in_req_i))
		else $error("input request changed or dropped before it was accepted");

endmodule

bind leak_obs_top leak_obs_checker u_checker (
	.clk_i       (clk_i),
	.rst_i       (rst_i),
	.in_valid_i  (in_valid_i),
	.in_req_i    (in_req_i),
	.in_ready_o  (in_ready_o),
	.out_valid_o (out_valid_o),
	.out_obs_o   (out_obs_o),
	.out_ready_i (out_ready_i)
);

//--- src/leak_obs_top.sv
`timescale 1ns/1ps

module leak_obs_top (
	input  logic                   clk_i,
	input  logic                   rst_i,
	input  logic                   in_valid_i,
	input  leak_obs_pkg::obs_req_t in_req_i,
	output logic                   in_ready_o,
	output logic                   out_valid_o,
	output leak_obs_pkg::obs_t     out_obs_o,
	input  logic                   out_ready_i
);

	logic dec_valid;
	logic dec_ready;
	leak_obs_pkg::dec_t dec;
	logic exe_valid;
	logic exe_ready;
	leak_obs_pkg::exe_t exe;

	// decode, execute, result: three slots in a row
	leak_obs_decode u_decode (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.in_valid_i  (in_valid_i),
		.in_req_i    (in_req_i),
		.in_ready_o  (in_ready_o),
		.dec_valid_o (dec_valid),
		.dec_o       (dec),
		.dec_ready_i (dec_ready)
	);

	leak_obs_execute u_execute (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.dec_valid_i (dec_valid),
		.dec_i       (dec),
		.dec_ready_o (dec_ready),
		.exe_valid_o (exe_valid),
		.exe_o       (exe),
		.exe_ready_i (exe_ready)
	);

	leak_obs_result u_result (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.exe_valid_i (exe_valid),
		.exe_i       (exe),
		.exe_ready_o (exe_ready),
		.out_valid_o (out_valid_o),
		.out_obs_o   (out_obs_o),
		.out_ready_i (out_ready_i)
	);

endmodule

//--- src/leak_obs_result.sv
`timescale 1ns/1ps

module leak_obs_result (
	input  logic               clk_i,
	input  logic               rst_i,
	input  logic               exe_valid_i,
	input  leak_obs_pkg::exe_t exe_i,
	output logic               exe_ready_o,
	output logic               out_valid_o,
	output leak_obs_pkg::obs_t out_obs_o,
	input  logic               out_ready_i
);

	logic is_mem;
	logic is_branch;
	logic is_muldiv;
	logic is_div;
	leak_obs_pkg::obs_t obs_d;
	leak_obs_pkg::obs_t obs_q;
	logic valid_q;

	assign is_mem = (exe_i.cls == leak_obs_pkg::OBS_LOAD) ||
		(exe_i.cls == leak_obs_pkg::OBS_STORE);
	assign is_branch = (exe_i.cls == leak_obs_pkg::OBS_BRANCH);
	assign is_div    = (exe_i.cls == leak_obs_pkg::OBS_DIV);
	assign is_muldiv = is_div || (exe_i.cls == leak_obs_pkg::OBS_MUL);

	// keep only what leaks for this class
	always_comb begin
		obs_d.cls        = exe_i.cls;
		obs_d.rs1        = exe_i.rs1;
		obs_d.rs2        = exe_i.rs2;
		obs_d.addr       = is_mem ? exe_i.addr : '0;
		obs_d.misaligned = is_mem & exe_i.misaligned;
		obs_d.taken      = is_branch & exe_i.taken;
		obs_d.op_b       = is_muldiv ? exe_i.op_b : '0;
		obs_d.div_zero   = is_div & exe_i.div_zero;
	end

	// record held until the consumer takes it
	assign exe_ready_o = ~valid_q | out_ready_i;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			valid_q <= 1'b0;
		end else if (exe_ready_o) begin
			valid_q <= exe_valid_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (exe_valid_i && exe_ready_o) begin
			obs_q <= obs_d;
		end
	end

	assign out_valid_o = valid_q;
	assign out_obs_o   = obs_q;

endmodule

//--- src/leak_obs_execute.sv
`timescale 1ns/1ps
`include "leak_obs_defines.svh"

module leak_obs_execute (
	input  logic               clk_i,
	input  logic               rst_i,
	input  logic               dec_valid_i,
	input  leak_obs_pkg::dec_t dec_i,
	output logic               dec_ready_o,
	output logic               exe_valid_o,
	output leak_obs_pkg::exe_t exe_o,
	input  logic               exe_ready_i
);

	logic [`LEAK_OBS_XLEN:0] addr_sum;
	logic [`LEAK_OBS_XLEN:0] cmp_sum;
	leak_obs_pkg::word_t addr;
	leak_obs_pkg::word_t diff;
	leak_obs_pkg::word_t op_a;
	leak_obs_pkg::word_t op_b;
	logic [1:0] offset;
	logic misaligned;
	logic is_equal;
	logic is_ge;
	logic cmp_signed;
	logic taken;
	leak_obs_pkg::exe_t exe_d;
	leak_obs_pkg::exe_t exe_q;
	logic valid_q;

	assign op_a = dec_i.rs1_val;
	assign op_b = dec_i.rs2_val;

	// effective address, low bit is a dummy carry-in of the shared adder shape
	assign addr_sum = {op_a, 1'b1} + {dec_i.imm, 1'b0};
	assign addr     = addr_sum[`LEAK_OBS_XLEN:1];
	assign offset   = addr[1:0];

	// access crosses a word boundary and is split in two
	assign misaligned = ((dec_i.size == leak_obs_pkg::SIZE_WORD) && (offset != 2'b00)) ||
		((dec_i.size == leak_obs_pkg::SIZE_HALF) && (offset == 2'b11));

	// a - b as a + ~b + 1, carry-in through the low bit
	assign cmp_sum  = {op_a, 1'b1} + ({op_b, 1'b0} ^ {(`LEAK_OBS_XLEN + 1){1'b1}});
	assign diff     = cmp_sum[`LEAK_OBS_XLEN:1];
	assign is_equal = (diff == '0);

	assign cmp_signed = (dec_i.cmp_op == leak_obs_pkg::CMP_LT) ||
		(dec_i.cmp_op == leak_obs_pkg::CMP_GE);

	always_comb begin
		// differing signs decide without the difference
		if ((op_a[`LEAK_OBS_XLEN-1] ^ op_b[`LEAK_OBS_XLEN-1]) == 1'b0) begin
			is_ge = ~diff[`LEAK_OBS_XLEN-1];
		end else begin
			is_ge = op_a[`LEAK_OBS_XLEN-1] ^ cmp_signed;
		end
	end

	always_comb begin
		case (dec_i.cmp_op)
			leak_obs_pkg::CMP_NE:  taken = ~is_equal;
			leak_obs_pkg::CMP_LT:  taken = ~is_ge;
			leak_obs_pkg::CMP_LTU: taken = ~is_ge;
			leak_obs_pkg::CMP_GE:  taken = is_ge;
			leak_obs_pkg::CMP_GEU: taken = is_ge;
			default:               taken = is_equal;
		endcase
	end

	always_comb begin
		exe_d.cls        = dec_i.cls;
		exe_d.rs1        = dec_i.rs1;
		exe_d.rs2        = dec_i.rs2;
		exe_d.addr       = addr;
		exe_d.misaligned = misaligned;
		exe_d.taken      = taken;
		exe_d.op_b       = op_b;
		exe_d.div_zero   = (op_b == '0);
	end

	assign dec_ready_o = ~valid_q | exe_ready_i;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			valid_q <= 1'b0;
		end else if (dec_ready_o) begin
			valid_q <= dec_valid_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (dec_valid_i && dec_ready_o) begin
			exe_q <= exe_d;
		end
	end

	assign exe_valid_o = valid_q;
	assign exe_o       = exe_q;

endmodule

//--- src/leak_obs_decode.sv
`timescale 1ns/1ps
`include "leak_obs_defines.svh"

module leak_obs_decode (
	input  logic                   clk_i,
	input  logic                   rst_i,
	input  logic                   in_valid_i,
	input  leak_obs_pkg::obs_req_t in_req_i,
	output logic                   in_ready_o,
	output logic                   dec_valid_o,
	output leak_obs_pkg::dec_t     dec_o,
	input  logic                   dec_ready_i
);

	leak_obs_pkg::word_t instr;
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	leak_obs_pkg::word_t imm_i;
	leak_obs_pkg::word_t imm_s;
	leak_obs_pkg::dec_t dec_d;
	leak_obs_pkg::dec_t dec_q;
	logic valid_q;

	assign instr  = in_req_i.instr;
	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];

	// sign extended immediates
	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};

	always_comb begin
		dec_d.cls     = leak_obs_pkg::OBS_OTHER;
		dec_d.imm     = '0;
		dec_d.rs1     = instr[19:15];
		dec_d.rs2     = instr[24:20];
		dec_d.rs1_val = in_req_i.rs1_val;
		dec_d.rs2_val = in_req_i.rs2_val;
		case (opcode)
			`LEAK_OBS_OPC_LOAD: begin
				dec_d.cls = leak_obs_pkg::OBS_LOAD;
				dec_d.imm = imm_i;
			end
			`LEAK_OBS_OPC_STORE: begin
				dec_d.cls = leak_obs_pkg::OBS_STORE;
				dec_d.imm = imm_s;
			end
			`LEAK_OBS_OPC_BRANCH: begin
				dec_d.cls = leak_obs_pkg::OBS_BRANCH;
			end
			`LEAK_OBS_OPC_OP: begin
				// upper half of funct3 is div/rem
				if (funct7 == `LEAK_OBS_F7_MULDIV) begin
					dec_d.cls = funct3[2] ? leak_obs_pkg::OBS_DIV : leak_obs_pkg::OBS_MUL;
				end
			end
			default: dec_d.cls = leak_obs_pkg::OBS_OTHER;
		endcase

		case (funct3)
			3'b001:  dec_d.cmp_op = leak_obs_pkg::CMP_NE;
			3'b100:  dec_d.cmp_op = leak_obs_pkg::CMP_LT;
			3'b101:  dec_d.cmp_op = leak_obs_pkg::CMP_GE;
			3'b110:  dec_d.cmp_op = leak_obs_pkg::CMP_LTU;
			3'b111:  dec_d.cmp_op = leak_obs_pkg::CMP_GEU;
			default: dec_d.cmp_op = leak_obs_pkg::CMP_EQ;
		endcase

		// unsigned loads share the size bits
		case (funct3[1:0])
			2'b00:   dec_d.size = leak_obs_pkg::SIZE_BYTE;
			2'b01:   dec_d.size = leak_obs_pkg::SIZE_HALF;
			default: dec_d.size = leak_obs_pkg::SIZE_WORD;
		endcase
	end

	// single register slot
	assign in_ready_o = ~valid_q | dec_ready_i;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			valid_q <= 1'b0;
		end else if (in_ready_o) begin
			valid_q <= in_valid_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (in_valid_i && in_ready_o) begin
			dec_q <= dec_d;
		end
	end

	assign dec_valid_o = valid_q;
	assign dec_o       = dec_q;

endmodule

//--- src/leak_obs_pkg.sv
`include "leak_obs_defines.svh"

package leak_obs_pkg;

	typedef logic [`LEAK_OBS_XLEN-1:0] word_t;
	typedef logic [`LEAK_OBS_REG_AW-1:0] reg_addr_t;

	// what the attacker learns depends on this class
	typedef enum logic [2:0] {
		OBS_OTHER,
		OBS_LOAD,
		OBS_STORE,
		OBS_BRANCH,
		OBS_MUL,
		OBS_DIV
	} obs_class_e;

	typedef enum logic [2:0] {
		CMP_EQ,
		CMP_NE,
		CMP_LT,
		CMP_GE,
		CMP_LTU,
		CMP_GEU
	} cmp_op_e;

	typedef enum logic [1:0] {
		SIZE_WORD,
		SIZE_HALF,
		SIZE_BYTE
	} lsu_size_e;

	// one retired instruction with its source operands
	typedef struct packed {
		word_t instr;
		word_t rs1_val;
		word_t rs2_val;
	} obs_req_t;

	typedef struct packed {
		obs_class_e cls;
		cmp_op_e cmp_op;
		lsu_size_e size;
		reg_addr_t rs1;
		reg_addr_t rs2;
		word_t imm;
		word_t rs1_val;
		word_t rs2_val;
	} dec_t;

	typedef struct packed {
		obs_class_e cls;
		reg_addr_t rs1;
		reg_addr_t rs2;
		word_t addr;
		logic misaligned;
		logic taken;
		word_t op_b;
		logic div_zero;
	} exe_t;

	// final record, fields not observable for the class are zero
	typedef struct packed {
		obs_class_e cls;
		reg_addr_t rs1;
		reg_addr_t rs2;
		word_t addr;
		logic misaligned;
		logic taken;
		word_t op_b;
		logic div_zero;
	} obs_t;

endpackage

//--- src/leak_obs_defines.svh
`ifndef LEAK_OBS_DEFINES_SVH
`define LEAK_OBS_DEFINES_SVH

// datapath and register file widths
`define LEAK_OBS_XLEN 32
`define LEAK_OBS_REG_AW 5

// RV32 major opcodes seen by the observer
`define LEAK_OBS_OPC_LOAD 7'h03
`define LEAK_OBS_OPC_STORE 7'h23
`define LEAK_OBS_OPC_BRANCH 7'h63
`define LEAK_OBS_OPC_OP 7'h33

// funct7 of the M extension inside the OP opcode
`define LEAK_OBS_F7_MULDIV 7'h01

`endif
